//--- flist.f
hw/csr_pkg.sv
hw/csr_req_port.sv
hw/csr_trap_regs.sv
hw/csr_perf_counters.sv
hw/csr_resp_port.sv
hw/csr_top.sv
tb/csr_top_asserts.sv
tb/tb_csr_top.sv

//--- hw/csr_perf_counters.sv
`default_nettype none

module csr_perf_counters #(
  parameter int unsigned N_COUNTERS = 4  // 1 .. MAX_COUNTERS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_access_t  access_i,
  input  csr_pkg::perf_events_t events_i,
  output csr_pkg::csr_read_t    rd_o
);
  import csr_pkg::*;

  logic [MAX_COUNTERS-1:0] evt_all;   // one source per counter slot
  logic [N_COUNTERS-1:0]   cnt_in;
  logic [N_COUNTERS-1:0]   cnt_inc;   // enabled event this cycle
  logic [N_COUNTERS-1:0]   cnt_inc_q; // applied one cycle later
  logic [N_COUNTERS-1:0]   pcer_q, pcer_d;
  logic [1:0]              pcmr_q, pcmr_d;  // [1] saturate, [0] global enable

  logic [N_COUNTERS-1:0][XLEN-1:0] cnt_q, cnt_d;

  logic [N_COUNTERS-1:0] cnt_sel;  // per-counter address match
  logic                  is_pcer, is_pcmr, is_all;
  logic                  hit;
  logic [XLEN-1:0]       old_val;
  logic [XLEN-1:0]       pcer_new, pcmr_new;

  // slot 0 always counts cycles
  assign evt_all = {events_i.store, events_i.load, events_i.instr_ret, 1'b1};
  assign cnt_in  = evt_all[N_COUNTERS-1:0];

  ////////////////////////////////////////////////////////////
  // address decode and read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    is_pcer = (access_i.addr == CSR_PCER);
    is_pcmr = (access_i.addr == CSR_PCMR);
    is_all  = (access_i.addr == CSR_PCCR_ALL);  // reads back zero
    old_val = '0;
    for (int c = 0; c < N_COUNTERS; c++) begin
      cnt_sel[c] = (access_i.addr == (12'(CSR_PCCR_BASE) + 12'(c)));
      if (cnt_sel[c]) old_val = cnt_q[c];
    end
    if (is_pcer) old_val = XLEN'(pcer_q);
    if (is_pcmr) old_val = XLEN'(pcmr_q);
    hit = is_pcer | is_pcmr | is_all | (|cnt_sel);
  end

  assign rd_o = '{hit: hit, data: old_val};

  ////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////

  assign pcer_new = csr_apply_op(access_i.op, XLEN'(pcer_q), access_i.wdata);
  assign pcmr_new = csr_apply_op(access_i.op, XLEN'(pcmr_q), access_i.wdata);

  always_comb begin
    pcer_d = pcer_q;
    pcmr_d = pcmr_q;
    if (access_i.strobe && is_pcer) pcer_d = pcer_new[N_COUNTERS-1:0];
    if (access_i.strobe && is_pcmr) pcmr_d = pcmr_new[1:0];
  end

  ////////////////////////////////////////////////////////////
  // counter update, bus write beats increment
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < N_COUNTERS; c++) begin
      cnt_inc[c] = cnt_in[c] & pcer_q[c] & pcmr_q[0];
      cnt_d[c]   = cnt_q[c];
      // stop at all-ones when saturating, else wrap
      if (cnt_inc_q[c] && ((cnt_q[c] != '1) || !pcmr_q[1])) begin
        cnt_d[c] = cnt_q[c] + XLEN'(1);
      end
      if (access_i.strobe && (is_all || cnt_sel[c])) begin
        cnt_d[c] = csr_apply_op(access_i.op, cnt_q[c], access_i.wdata);
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pcer_q    <= '0;
      pcmr_q    <= 2'b11;  // counting on, saturation on
      cnt_q     <= '0;
      cnt_inc_q <= '0;
    end else begin
      pcer_q    <= pcer_d;
      pcmr_q    <= pcmr_d;
      cnt_q     <= cnt_d;
      cnt_inc_q <= cnt_inc;
    end
  end

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths, addresses, op codes
  ////////////////////////////////////////////////////////////

  parameter int unsigned XLEN         = 32;
  parameter int unsigned MAX_COUNTERS = 4;  // cycle, instret, load, store

  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MTVEC     = 12'h305,  // read-only, boot address
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_PCCR_BASE = 12'h780,  // counter i at base + i
    CSR_PCCR_ALL  = 12'h79F,  // write hits every counter
    CSR_PCER      = 12'h7A0,
    CSR_PCMR      = 12'h7A1
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // mstatus bit positions
  parameter int unsigned MSTATUS_MIE_BIT  = 3;
  parameter int unsigned MSTATUS_MPIE_BIT = 7;

  // misa: mxl=1 (rv32), I and C only
  parameter logic [XLEN-1:0] MISA_VALUE =
      (XLEN'(1) << 30)   // mxl
    | (XLEN'(1) <<  8)   // I
    | (XLEN'(1) <<  2);  // C

  ////////////////////////////////////////////////////////////
  // payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [11:0]     addr;
    csr_op_e         op;
    logic [XLEN-1:0] wdata;
  } csr_req_t;  // 46 bits

  typedef struct packed {
    logic            strobe;  // one cycle per accepted request
    logic [11:0]     addr;
    csr_op_e         op;
    logic [XLEN-1:0] wdata;
  } csr_access_t;  // 47 bits

  typedef struct packed {
    logic            hit;
    logic [XLEN-1:0] data;  // old value, zero on miss
  } csr_read_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;  // nobody claimed the address
  } csr_resp_t;

  typedef struct packed {
    logic            save;
    logic [5:0]      cause;  // {irq, code[4:0]}
    logic [XLEN-1:0] pc;
  } trap_event_t;

  typedef struct packed {
    logic instr_ret;
    logic load;
    logic store;
  } perf_events_t;

  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  // write/set/clear against the old value, none keeps it
  function automatic logic [XLEN-1:0] csr_apply_op(input csr_op_e         op,
                                                   input logic [XLEN-1:0] old_val,
                                                   input logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] res;
    unique case (op)
      CSR_OP_WRITE: res = wdata;
      CSR_OP_SET:   res = old_val | wdata;
      CSR_OP_CLEAR: res = old_val & ~wdata;  // clear = old and not wdata
      default:      res = old_val;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

//--- hw/csr_req_port.sv
`default_nettype none

module csr_req_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  csr_pkg::csr_req_t    req_data_i,
  output logic                 ack_o,
  output csr_pkg::csr_access_t access_o
);
  import csr_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,    // waiting for req
    ST_STROBE,  // access strobe out this cycle
    ST_HOLD     // ack high until req drops
  } state_e;

  state_e   state_q, state_d;
  logic     ack_q, ack_d;
  logic     accept;  // new request taken at this edge
  csr_req_t req_q;   // frozen copy of the bus

  assign accept = (state_q == ST_IDLE) && req_i && !ack_q;

  ////////////////////////////////////////////////////////////
  // four-phase slave
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ack_d   = ack_q;
    unique case (state_q)
      ST_IDLE: begin
        if (accept) state_d = ST_STROBE;
      end
      ST_STROBE: begin
        state_d = ST_HOLD;  // single strobe, then ack
        ack_d   = 1'b1;
      end
      ST_HOLD: begin
        if (!req_i) begin  // phase 3 seen
          state_d = ST_IDLE;
          ack_d   = 1'b0;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (accept) req_q <= req_data_i;
  end

  assign ack_o    = ack_q;
  assign access_o = '{strobe: (state_q == ST_STROBE),
                      addr:   req_q.addr,
                      op:     req_q.op,
                      wdata:  req_q.wdata};

endmodule

`default_nettype wire

//--- hw/csr_resp_port.sv
`default_nettype none

module csr_resp_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_access_t access_i,
  input  csr_pkg::csr_read_t   trap_rd_i,
  input  csr_pkg::csr_read_t   perf_rd_i,
  output csr_pkg::csr_resp_t   rsp_o
);
  import csr_pkg::*;

  ////////////////////////////////////////////////////////////
  // merge the block answers
  ////////////////////////////////////////////////////////////

  logic [XLEN-1:0] merged;   // misses drive zero, so OR is enough
  logic            any_hit;
  csr_resp_t       rsp_q;

  assign merged  = trap_rd_i.data | perf_rd_i.data;
  assign any_hit = trap_rd_i.hit | perf_rd_i.hit;

  // capture once per access, hold until the next one
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else if (access_i.strobe) begin
      rsp_q.rdata <= merged;
      rsp_q.err   <= !any_hit;  // unclaimed address
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

//--- hw/csr_top.sv
`default_nettype none

module csr_top #(
  parameter int unsigned N_COUNTERS = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // requester, four-phase
  input  logic                     req_i,
  input  csr_pkg::csr_req_t        req_data_i,
  output logic                     ack_o,
  output csr_pkg::csr_resp_t       rsp_o,
  // core side, no handshake
  input  csr_pkg::trap_event_t     trap_i,
  input  logic                     mret_i,
  input  csr_pkg::perf_events_t    events_i,
  input  logic [csr_pkg::XLEN-1:0] boot_addr_i,
  output logic                     m_irq_enable_o,
  output logic [csr_pkg::XLEN-1:0] mepc_o
);
  import csr_pkg::*;

  csr_access_t access;   // strobed request, stable payload
  csr_read_t   trap_rd;
  csr_read_t   perf_rd;

  ////////////////////////////////////////////////////////////
  // input side, processing, output side
  ////////////////////////////////////////////////////////////

  csr_req_port u_req_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .access_o   (access)
  );

  csr_trap_regs u_trap_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .access_i       (access),
    .trap_i         (trap_i),
    .mret_i         (mret_i),
    .boot_addr_i    (boot_addr_i),
    .rd_o           (trap_rd),
    .m_irq_enable_o (m_irq_enable_o),
    .mepc_o         (mepc_o)
  );

  csr_perf_counters #(
    .N_COUNTERS (N_COUNTERS)
  ) u_perf_counters (
    .clk      (clk),
    .rst_n    (rst_n),
    .access_i (access),
    .events_i (events_i),
    .rd_o     (perf_rd)
  );

  csr_resp_port u_resp_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .access_i  (access),
    .trap_rd_i (trap_rd),
    .perf_rd_i (perf_rd),
    .rsp_o     (rsp_o)
  );

endmodule

`default_nettype wire

//--- hw/csr_trap_regs.sv
`default_nettype none

module csr_trap_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  csr_pkg::csr_access_t          access_i,
  input  csr_pkg::trap_event_t          trap_i,
  input  logic                          mret_i,
  input  logic [csr_pkg::XLEN-1:0]      boot_addr_i,
  output csr_pkg::csr_read_t            rd_o,
  output logic                          m_irq_enable_o,
  output logic [csr_pkg::XLEN-1:0]      mepc_o
);
  import csr_pkg::*;

  mstatus_t        mstatus_q, mstatus_d;
  logic [XLEN-1:0] mepc_q, mepc_d;
  logic [5:0]      mcause_q, mcause_d;  // {irq, code}

  logic            hit;
  logic [XLEN-1:0] old_val;  // value before the access
  logic [XLEN-1:0] new_val;  // after write/set/clear
  logic            wr;

  ////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit     = 1'b1;
    old_val = '0;
    case (access_i.addr)
      CSR_MSTATUS: begin
        old_val[12:11]            = 2'b11;  // mpp fixed to machine
        old_val[MSTATUS_MIE_BIT]  = mstatus_q.mie;
        old_val[MSTATUS_MPIE_BIT] = mstatus_q.mpie;
      end
      CSR_MISA:   old_val = MISA_VALUE;
      CSR_MTVEC:  old_val = boot_addr_i;  // vector base = boot addr
      CSR_MEPC:   old_val = mepc_q;
      CSR_MCAUSE: old_val = {mcause_q[5], {(XLEN-6){1'b0}}, mcause_q[4:0]};
      default:    hit = 1'b0;  // not ours
    endcase
  end

  assign rd_o    = '{hit: hit, data: old_val};
  assign new_val = csr_apply_op(access_i.op, old_val, access_i.wdata);
  assign wr      = access_i.strobe && hit;

  ////////////////////////////////////////////////////////////
  // next state, trap > mret > bus write
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    if (wr) begin
      case (access_i.addr)
        CSR_MSTATUS: begin
          mstatus_d.mie  = new_val[MSTATUS_MIE_BIT];
          mstatus_d.mpie = new_val[MSTATUS_MPIE_BIT];
        end
        CSR_MEPC:   mepc_d   = new_val;
        CSR_MCAUSE: mcause_d = {new_val[XLEN-1], new_val[4:0]};
        default: ;  // misa, mtvec ignore writes
      endcase
    end

    if (trap_i.save) begin
      // trap entry overrides whatever the bus did
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = trap_i.pc;
      mcause_d       = trap_i.cause;
    end else if (mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;  // restore
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  assign m_irq_enable_o = mstatus_q.mie;
  assign mepc_o         = mepc_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the CSR block testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_top -f flist.f --Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_csr_top +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi
echo "simulation passed"
exit 0

//--- tb/csr_top_asserts.sv
`default_nettype none

module csr_top_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req_i,
  input logic                 ack_i,
  input csr_pkg::csr_access_t access_i,
  input csr_pkg::trap_event_t trap_i,
  input logic                 mie_i
);

  int unsigned rise_fails   = 0;
  int unsigned fall_fails   = 0;
  int unsigned strobe_fails = 0;
  int unsigned trap_fails   = 0;
  int unsigned fail_count;  // summed for the testbench

  assign fail_count = rise_fails + fall_fails + strobe_fails + trap_fails;

  ////////////////////////////////////////////////////////////
  // four-phase handshake
  ////////////////////////////////////////////////////////////

  ack_rise_on_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack_i) |-> $past(req_i))
    else begin
      $error("ack rose without a pending req");
      rise_fails++;
    end

  ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(ack_i) |-> !$past(req_i))  // phase 3 first
    else begin
      $error("ack fell while req was still high");
      fall_fails++;
    end

  strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
      access_i.strobe |=> !access_i.strobe)
    else begin
      $error("access strobe lasted two cycles");
      strobe_fails++;
    end

  // trap entry clears mie at the ending edge
  trap_clears_mie: assert property (@(posedge clk) disable iff (!rst_n)
      trap_i.save |=> !mie_i)
    else begin
      $error("mie still set in the cycle after a trap");
      trap_fails++;
    end

endmodule

bind csr_top csr_top_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .access_i (access),
  .trap_i   (trap_i),
  .mie_i    (m_irq_enable_o)
);

`default_nettype wire

//--- tb/tb_csr_top.sv
`default_nettype none

module tb_csr_top;
  import csr_pkg::*;

  localparam int unsigned N_CNT = 4;
  // about 45 accesses of ~6 cycles plus ~70 event cycles, with wide margin
  localparam int unsigned TIMEOUT_CYCLES = 3000;
  localparam logic [XLEN-1:0] MISA_EXP = 32'h4000_0104;  // mxl=1, I bit 8, C bit 2

  logic         clk;
  logic         rst_n;
  logic         req;
  csr_req_t     req_data;
  logic         ack;
  csr_resp_t    rsp;
  trap_event_t  trap;
  logic         mret;
  perf_events_t events;
  logic [XLEN-1:0] boot_addr;
  logic         mie;
  logic [XLEN-1:0] mepc;

  int unsigned error_count = 0;
  int unsigned cycle_cnt   = 0;
  int unsigned ack_cycle   = 0;  // cycle where ack was first seen high
  logic        exp_mie, exp_mpie;  // mstatus model
  logic [XLEN-1:0] exp_mepc;       // last pc saved by a trap

  csr_top #(
    .N_COUNTERS (N_CNT)
  ) dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .req_data_i     (req_data),
    .ack_o          (ack),
    .rsp_o          (rsp),
    .trap_i         (trap),
    .mret_i         (mret),
    .events_i       (events),
    .boot_addr_i    (boot_addr),
    .m_irq_enable_o (mie),
    .mepc_o         (mepc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // mpp always 11, only mie and mpie stick
  function automatic logic [XLEN-1:0] mstatus_word(input logic ie, input logic pie);
    logic [XLEN-1:0] w;
    w    = 32'h0000_1800;
    w[3] = ie;
    w[7] = pie;
    return w;
  endfunction

  function automatic logic [11:0] pccr_addr(input int unsigned idx);
    return 12'h780 + 12'(idx);  // counter i at 0x780 + i
  endfunction

  task automatic report_mismatch(input string what, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    $display("ERROR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    error_count++;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #5;
    end
  endtask

  // phase 1, caller sits just after an edge
  task automatic start_req(input logic [11:0] addr, input csr_op_e op,
                           input logic [XLEN-1:0] wdata);
    req_data.addr  = addr;
    req_data.op    = op;
    req_data.wdata = wdata;
    req            = 1'b1;
  endtask

  task automatic wait_ack_high();
    do begin
      @(posedge clk);
      #5;
    end while (!ack);
    ack_cycle = cycle_cnt;
  endtask

  // phases 3 and 4
  task automatic release_req();
    req = 1'b0;
    do begin
      @(posedge clk);
      #5;
    end while (ack);
  endtask

  task automatic csr_access(input logic [11:0] addr, input csr_op_e op,
                            input logic [XLEN-1:0] wdata,
                            output logic [XLEN-1:0] rdata, output logic err);
    @(posedge clk);
    #5;
    start_req(addr, op, wdata);
    wait_ack_high();
    rdata = rsp.rdata;  // valid while ack high
    err   = rsp.err;
    release_req();
  endtask

  task automatic expect_read(input logic [11:0] addr, input logic [XLEN-1:0] exp,
                             input string what);
    logic [XLEN-1:0] rdata;
    logic            err;
    csr_access(addr, CSR_OP_NONE, '0, rdata, err);
    if (err !== 1'b0) report_mismatch({what, " err"}, {31'b0, err}, '0);
    if (rdata !== exp) report_mismatch(what, rdata, exp);
  endtask

  // write and check the old value in one go
  task automatic write_old(input logic [11:0] addr, input csr_op_e op,
                           input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] exp_old,
                           input string what);
    logic [XLEN-1:0] rdata;
    logic            err;
    csr_access(addr, op, wdata, rdata, err);
    if (err !== 1'b0) report_mismatch({what, " err"}, {31'b0, err}, '0);
    if (rdata !== exp_old) report_mismatch(what, rdata, exp_old);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_mstatus_ops();
    logic [XLEN-1:0] w;
    logic [XLEN-1:0] rdata;
    logic            err;
    w = $urandom;
    write_old(CSR_MSTATUS, CSR_OP_WRITE, w, mstatus_word(exp_mie, exp_mpie), "mstatus write");
    exp_mie  = w[3];
    exp_mpie = w[7];
    write_old(CSR_MSTATUS, CSR_OP_SET, 32'hFFFF_FFFF, mstatus_word(exp_mie, exp_mpie),
              "mstatus set");
    exp_mie  = 1'b1;
    exp_mpie = 1'b1;
    write_old(CSR_MSTATUS, CSR_OP_CLEAR, 32'h0000_0008, mstatus_word(1'b1, 1'b1),
              "mstatus clear");
    exp_mie = 1'b0;
    expect_read(CSR_MSTATUS, mstatus_word(exp_mie, exp_mpie), "mstatus after clear");
    expect_read(CSR_MISA, MISA_EXP, "misa");
    write_old(CSR_MISA, CSR_OP_WRITE, $urandom, MISA_EXP, "misa write");
    expect_read(CSR_MISA, MISA_EXP, "misa after write");  // writes ignored
    expect_read(CSR_MTVEC, boot_addr, "mtvec");
    csr_access(12'h123, CSR_OP_NONE, '0, rdata, err);  // unclaimed address
    if (err !== 1'b1) report_mismatch("err on 0x123", {31'b0, err}, 1);
    if (rdata !== '0) report_mismatch("rdata on 0x123", rdata, '0);
  endtask

  task automatic test_trap_mret();
    logic [XLEN-1:0] pc;
    logic [5:0]      cause;
    write_old(CSR_MSTATUS, CSR_OP_WRITE, 32'h0000_0008, mstatus_word(exp_mie, exp_mpie),
              "mstatus enable mie");
    exp_mie  = 1'b1;
    exp_mpie = 1'b0;
    pc    = $urandom;
    cause = 6'($urandom);
    trap  = '{save: 1'b1, cause: cause, pc: pc};  // one cycle pulse
    idle_cycles(1);
    trap.save = 1'b0;
    exp_mpie  = exp_mie;
    exp_mie   = 1'b0;
    exp_mepc  = pc;
    if (mepc !== pc) report_mismatch("mepc_o after trap", mepc, pc);
    if (mie !== 1'b0) report_mismatch("mie_o after trap", {31'b0, mie}, '0);
    expect_read(CSR_MEPC, pc, "mepc after trap");
    expect_read(CSR_MCAUSE, {cause[5], 26'b0, cause[4:0]}, "mcause after trap");
    expect_read(CSR_MSTATUS, mstatus_word(exp_mie, exp_mpie), "mstatus after trap");
    mret = 1'b1;
    idle_cycles(1);
    mret     = 1'b0;
    exp_mie  = exp_mpie;  // restored
    exp_mpie = 1'b1;
    if (mie !== 1'b1) report_mismatch("mie_o after mret", {31'b0, mie}, 1);
    expect_read(CSR_MSTATUS, mstatus_word(exp_mie, exp_mpie), "mstatus after mret");
  endtask

  task automatic test_trap_priority();
    logic [XLEN-1:0] w, pc, rdata;
    logic            err;
    w      = $urandom;
    pc     = $urandom;
    @(posedge clk);
    #5;
    start_req(CSR_MEPC, CSR_OP_WRITE, w);
    idle_cycles(1);  // req sampled at that edge, strobe cycle now
    trap = '{save: 1'b1, cause: 6'($urandom), pc: pc};
    idle_cycles(1);
    trap.save = 1'b0;
    if (ack !== 1'b1) report_mismatch("ack two edges after req", {31'b0, ack}, 1);
    rdata = rsp.rdata;
    err   = rsp.err;
    release_req();
    if (err !== 1'b0) report_mismatch("mepc write err", {31'b0, err}, '0);
    if (rdata !== exp_mepc) report_mismatch("mepc old value", rdata, exp_mepc);
    exp_mpie = exp_mie;
    exp_mie  = 1'b0;
    exp_mepc = pc;
    expect_read(CSR_MEPC, pc, "mepc after trap over write");
  endtask

  task automatic test_counting();
    int unsigned     n_cycles;
    logic [XLEN-1:0] n_loads;
    n_loads = '0;
    write_old(CSR_PCER, CSR_OP_WRITE, '0, '0, "pcer at start");
    write_old(CSR_PCCR_ALL, CSR_OP_WRITE, '0, '0, "pccr all");  // all counters cleared
    write_old(CSR_PCER, CSR_OP_WRITE, 32'h0000_0004, '0, "pcer load only");
    n_cycles = 10 + ($urandom % 20);
    repeat (n_cycles) begin
      events = 3'($urandom);  // loads mixed with retire and store
      if (events.load) n_loads = n_loads + 1;
      idle_cycles(1);
    end
    events = '0;
    idle_cycles(4);
    expect_read(pccr_addr(2), n_loads, "load counter");
    expect_read(pccr_addr(3), '0, "store counter disabled");
    expect_read(pccr_addr(1), '0, "retire counter disabled");
    write_old(CSR_PCMR, CSR_OP_CLEAR, 32'h0000_0001, 32'h0000_0003, "pcmr clear enable");
    events.load = 1'b1;
    idle_cycles(8);
    events = '0;
    idle_cycles(4);
    expect_read(pccr_addr(2), n_loads, "load counter while disabled");
  endtask

  task automatic test_saturation();
    logic [XLEN-1:0] rdata;
    logic            err;
    int unsigned     w_cycle;
    write_old(CSR_PCMR, CSR_OP_WRITE, 32'h0000_0003, 32'h0000_0002, "pcmr saturate");
    write_old(CSR_PCER, CSR_OP_WRITE, 32'h0000_0001, 32'h0000_0004, "pcer cycles only");
    csr_access(pccr_addr(0), CSR_OP_WRITE, 32'hFFFF_FFFD, rdata, err);
    idle_cycles(8);
    expect_read(pccr_addr(0), 32'hFFFF_FFFF, "counter 0 saturated");
    write_old(CSR_PCMR, CSR_OP_WRITE, 32'h0000_0001, 32'h0000_0003, "pcmr wrap");
    csr_access(pccr_addr(0), CSR_OP_WRITE, 32'hFFFF_FFFD, rdata, err);
    w_cycle = ack_cycle;
    idle_cycles(8);
    csr_access(pccr_addr(0), CSR_OP_NONE, '0, rdata, err);
    if (rdata >= XLEN'(ack_cycle - w_cycle)) begin
      $display("ERROR %0t: counter 0 read 0x%08h, expected a wrapped value below %0d",
               $time, rdata, ack_cycle - w_cycle);
      error_count++;
    end
  endtask

  task automatic test_back_pressure();
    logic [XLEN-1:0] first;
    write_old(CSR_MSTATUS, CSR_OP_CLEAR, 32'h0000_0008, mstatus_word(exp_mie, exp_mpie),
              "mstatus clear before hold");
    exp_mie = 1'b0;
    @(posedge clk);
    #5;
    start_req(CSR_MSTATUS, CSR_OP_SET, 32'h0000_0008);
    wait_ack_high();
    first = rsp.rdata;
    if (first !== mstatus_word(1'b0, exp_mpie)) report_mismatch("held set old", first,
                                                                mstatus_word(1'b0, exp_mpie));
    repeat (10) begin
      idle_cycles(1);
      if (ack !== 1'b1) report_mismatch("ack during hold", {31'b0, ack}, 1);
      if (rsp.rdata !== first) report_mismatch("rsp during hold", rsp.rdata, first);
    end
    release_req();
    exp_mie = 1'b1;
    // set then clear must leave mie low
    write_old(CSR_MSTATUS, CSR_OP_CLEAR, 32'h0000_0008, mstatus_word(exp_mie, exp_mpie),
              "mstatus clear after hold");
    exp_mie = 1'b0;
    expect_read(CSR_MSTATUS, mstatus_word(exp_mie, exp_mpie), "mstatus after set, clear");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hf41a));
    rst_n     = 1'b0;
    req       = 1'b0;
    req_data  = '0;
    trap      = '0;
    mret      = 1'b0;
    events    = '0;
    boot_addr = $urandom & 32'hFFFF_FFFC;  // word aligned vector base
    exp_mie   = 1'b0;
    exp_mpie  = 1'b0;
    exp_mepc  = '0;
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;

    test_mstatus_ops();
    test_trap_mret();
    test_trap_priority();
    test_counting();
    test_saturation();
    test_back_pressure();
    idle_cycles(2);

    $display("tests done: %0d check errors, %0d assertion failures",
             error_count, dut.u_asserts.fail_count);
    if ((error_count == 0) && (dut.u_asserts.fail_count == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
